// ==== source/video_macros.svh ====
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Mode timing in pixels and lines: active, front porch, sync, back porch
////////////////////////////////////////////////////////////////////////////

// 640x480, 25 MHz pixel clock
`define VGA_HPX      11'd640
`define VGA_HFP      11'd16
`define VGA_HSW      11'd96
`define VGA_HBP      11'd48
`define VGA_VLN      11'd480
`define VGA_VFP      11'd11
`define VGA_VSW      11'd2
`define VGA_VBP      11'd31
`define VGA_NEG      1'b1     // Negative sync
`define VGA_M        8'd2
`define VGA_D        8'd4

// 800x600, 40 MHz
`define SVGA_HPX     11'd800
`define SVGA_HFP     11'd40
`define SVGA_HSW     11'd128
`define SVGA_HBP     11'd88
`define SVGA_VLN     11'd600
`define SVGA_VFP     11'd1
`define SVGA_VSW     11'd4
`define SVGA_VBP     11'd23
`define SVGA_NEG     1'b0
`define SVGA_M       8'd4
`define SVGA_D       8'd5

// 1024x768, 65 MHz
`define XGA_HPX      11'd1024
`define XGA_HFP      11'd24
`define XGA_HSW      11'd136
`define XGA_HBP      11'd160
`define XGA_VLN      11'd768
`define XGA_VFP      11'd3
`define XGA_VSW      11'd6
`define XGA_VBP      11'd29
`define XGA_NEG      1'b1     // Negative sync
`define XGA_M        8'd13
`define XGA_D        8'd10

// 1280x720, 74.25 MHz, also the default mode
`define HD720P_HPX   11'd1280
`define HD720P_HFP   11'd110
`define HD720P_HSW   11'd40
`define HD720P_HBP   11'd220
`define HD720P_VLN   11'd720
`define HD720P_VFP   11'd5
`define HD720P_VSW   11'd5
`define HD720P_VBP   11'd20
`define HD720P_NEG   1'b0
`define HD720P_M     8'd248
`define HD720P_D     8'd167

// 1280x1024, 108 MHz
`define SXGA_HPX     11'd1280
`define SXGA_HFP     11'd48
`define SXGA_HSW     11'd112
`define SXGA_HBP     11'd248
`define SXGA_VLN     11'd1024
`define SXGA_VFP     11'd1
`define SXGA_VSW     11'd3
`define SXGA_VBP     11'd38
`define SXGA_NEG     1'b0
`define SXGA_M       8'd54
`define SXGA_D       8'd25

// Switch codes
`define SW_VGA       4'b0000
`define SW_SVGA      4'b0001
`define SW_XGA       4'b0011
`define SW_HD720P    4'b0010
`define SW_SXGA      4'b1000

`define DEBOUNCE_CYCLES 16    // Stable cycles before a new code is taken

// Synthesizer command opcodes, sent ahead of the value
`define OP_LOAD_D    2'b01
`define OP_LOAD_M    2'b11

`endif

// ==== source/video_pkg.sv ====
`default_nettype none

package video_pkg;

	// Pixel or line count, thresholds too (max total is 1688)
	typedef logic [10:0] coord_t;

	// Raw mode switches
	typedef logic [3:0] sw_code_t;

	// Synthesizer M or D, held as value minus one
	typedef logic [7:0] div_t;

	// One colour channel
	typedef logic [7:0] pixel_t;

	// Latched video mode
	typedef enum logic [2:0] {
		MODE_VGA    = 3'd0,
		MODE_SVGA   = 3'd1,
		MODE_XGA    = 3'd2,
		MODE_HD720P = 3'd3,
		MODE_SXGA   = 3'd4
	} mode_t;

	// Serial programming sequencer
	typedef enum logic [2:0] {
		PROG_IDLE    = 3'd0,
		PROG_SHIFT_D = 3'd1, // D command frame
		PROG_GAP_D   = 3'd2,
		PROG_SHIFT_M = 3'd3, // M command frame
		PROG_GAP_M   = 3'd4,
		PROG_GO      = 3'd5,
		PROG_WAIT    = 3'd6  // Until synthesizer reports done
	} prog_state_t;

endpackage

`default_nettype wire

// ==== source/mode_select.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "video_macros.svh"

module mode_select (
	input  wire                      clk50m_bufg,
	input  wire                      RSTBTN,
	input  wire video_pkg::sw_code_t mode_sw,      // Async switches
	output video_pkg::mode_t         mode,
	output logic                     mode_load,    // One cycle per new mode
	output video_pkg::coord_t        h_active_end,
	output video_pkg::coord_t        h_sync_start,
	output video_pkg::coord_t        h_sync_end,
	output video_pkg::coord_t        h_total,
	output video_pkg::coord_t        v_active_end,
	output video_pkg::coord_t        v_sync_start,
	output video_pkg::coord_t        v_sync_end,
	output video_pkg::coord_t        v_total,
	output logic                     sync_neg,     // 1 = negative sync
	output video_pkg::div_t          pclk_m,
	output video_pkg::div_t          pclk_d
);
	import video_pkg::*;

	localparam logic [4:0] DEB_LAST = 5'(`DEBOUNCE_CYCLES - 1);

	sw_code_t   sw_meta;
	sw_code_t   sw_sync;
	sw_code_t   code_q;      // Code of the mode in force
	sw_code_t   cand_q;      // Code under debounce
	logic [4:0] deb_cnt;     // Stable cycles seen so far
	logic       init_q;      // Forces a load right after reset
	logic       take;
	mode_t      nxt_mode;
	coord_t     hpx, hfp, hsw, hbp;
	coord_t     vln, vfp, vsw, vbp;
	logic       neg;
	div_t       m_raw, d_raw;

	// Two-flop synchronizer
	always_ff @(posedge clk50m_bufg) begin
		sw_meta <= mode_sw;
		sw_sync <= sw_meta;
	end

	// DEBOUNCE_CYCLES-th stable cycle of a new code, or first cycle out of reset
	assign take = init_q ||
		(sw_sync != code_q && sw_sync == cand_q && deb_cnt == DEB_LAST);

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			init_q    <= 1'b1;
			code_q    <= `SW_HD720P;
			cand_q    <= `SW_HD720P;
			deb_cnt   <= '0;
			mode_load <= 1'b0;
		end else begin
			init_q    <= 1'b0;
			mode_load <= take;
			if (take) begin
				code_q  <= sw_sync;
				deb_cnt <= '0;
			end else if (sw_sync == code_q) begin
				deb_cnt <= '0;                 // Back to current code
			end else if (sw_sync != cand_q) begin
				cand_q  <= sw_sync;            // New candidate, first cycle
				deb_cnt <= 5'd1;
			end else begin
				deb_cnt <= deb_cnt + 5'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Mode decode
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		case (sw_sync)
			`SW_VGA: begin
				nxt_mode = MODE_VGA;
				{hpx, hfp, hsw, hbp} = {`VGA_HPX, `VGA_HFP, `VGA_HSW, `VGA_HBP};
				{vln, vfp, vsw, vbp} = {`VGA_VLN, `VGA_VFP, `VGA_VSW, `VGA_VBP};
				{neg, m_raw, d_raw}  = {`VGA_NEG, `VGA_M, `VGA_D};
			end
			`SW_SVGA: begin
				nxt_mode = MODE_SVGA;
				{hpx, hfp, hsw, hbp} = {`SVGA_HPX, `SVGA_HFP, `SVGA_HSW, `SVGA_HBP};
				{vln, vfp, vsw, vbp} = {`SVGA_VLN, `SVGA_VFP, `SVGA_VSW, `SVGA_VBP};
				{neg, m_raw, d_raw}  = {`SVGA_NEG, `SVGA_M, `SVGA_D};
			end
			`SW_XGA: begin
				nxt_mode = MODE_XGA;
				{hpx, hfp, hsw, hbp} = {`XGA_HPX, `XGA_HFP, `XGA_HSW, `XGA_HBP};
				{vln, vfp, vsw, vbp} = {`XGA_VLN, `XGA_VFP, `XGA_VSW, `XGA_VBP};
				{neg, m_raw, d_raw}  = {`XGA_NEG, `XGA_M, `XGA_D};
			end
			`SW_SXGA: begin
				nxt_mode = MODE_SXGA;
				{hpx, hfp, hsw, hbp} = {`SXGA_HPX, `SXGA_HFP, `SXGA_HSW, `SXGA_HBP};
				{vln, vfp, vsw, vbp} = {`SXGA_VLN, `SXGA_VFP, `SXGA_VSW, `SXGA_VBP};
				{neg, m_raw, d_raw}  = {`SXGA_NEG, `SXGA_M, `SXGA_D};
			end
			default: begin // 720p, any unlisted code lands here
				nxt_mode = MODE_HD720P;
				{hpx, hfp, hsw, hbp} = {`HD720P_HPX, `HD720P_HFP, `HD720P_HSW, `HD720P_HBP};
				{vln, vfp, vsw, vbp} = {`HD720P_VLN, `HD720P_VFP, `HD720P_VSW, `HD720P_VBP};
				{neg, m_raw, d_raw}  = {`HD720P_NEG, `HD720P_M, `HD720P_D};
			end
		endcase
	end

	// Thresholds move on the same edge that raises mode_load
	always_ff @(posedge clk50m_bufg) begin
		if (take) begin
			mode         <= nxt_mode;
			h_active_end <= hpx;
			h_sync_start <= hpx + hfp;
			h_sync_end   <= hpx + hfp + hsw;
			h_total      <= hpx + hfp + hsw + hbp;
			v_active_end <= vln;
			v_sync_start <= vln + vfp;
			v_sync_end   <= vln + vfp + vsw;
			v_total      <= vln + vfp + vsw + vbp;
			sync_neg     <= neg;
			pclk_m       <= m_raw - 8'd1;       // Synthesizer wants value-1
			pclk_d       <= d_raw - 8'd1;
		end
	end

	// Debounce spacing keeps loads apart
	a_load_single: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		mode_load |=> !mode_load);

endmodule

`default_nettype wire

// ==== source/dcm_prog.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "video_macros.svh"

module dcm_prog (
	input  wire                   clk50m_bufg,
	input  wire                   RSTBTN,
	input  wire                   mode_load,   // Start, also restarts
	input  wire video_pkg::div_t  pclk_m,
	input  wire video_pkg::div_t  pclk_d,
	input  wire                   prog_done,   // Level from synthesizer
	output logic                  prog_en,
	output logic                  prog_data,
	output logic                  prog_busy
);
	import video_pkg::*;

	localparam logic [3:0] LAST_BIT = 4'd9; // 2 opcode bits + 8 value bits

	prog_state_t state_q;
	logic [9:0]  sh_q;    // Frame, LSB goes out first
	logic [3:0]  bit_q;
	logic        shifting;

	assign shifting = (state_q == PROG_SHIFT_D) || (state_q == PROG_SHIFT_M);

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			state_q   <= PROG_IDLE;
			bit_q     <= '0;
			prog_busy <= 1'b0;
		end else if (mode_load) begin
			state_q   <= PROG_SHIFT_D;      // Restart even mid-sequence
			bit_q     <= '0;
			prog_busy <= 1'b1;
		end else begin
			case (state_q)
				PROG_SHIFT_D, PROG_SHIFT_M: begin
					bit_q <= bit_q + 4'd1;
					if (bit_q == LAST_BIT) begin
						bit_q   <= '0;
						state_q <= (state_q == PROG_SHIFT_D) ? PROG_GAP_D : PROG_GAP_M;
					end
				end
				PROG_GAP_D: state_q <= PROG_SHIFT_M;
				PROG_GAP_M: state_q <= PROG_GO;
				PROG_GO:    state_q <= PROG_WAIT;
				PROG_WAIT: begin
					if (prog_done) begin
						state_q   <= PROG_IDLE;
						prog_busy <= 1'b0;
					end
				end
				default: state_q <= PROG_IDLE;
			endcase
		end
	end

	// D frame on start, M frame loaded in the gap
	always_ff @(posedge clk50m_bufg) begin
		if (mode_load) begin
			sh_q <= {pclk_d, `OP_LOAD_D};
		end else if (state_q == PROG_GAP_D) begin
			sh_q <= {pclk_m, `OP_LOAD_M};
		end else begin
			sh_q <= {1'b0, sh_q[9:1]};
		end
	end

	assign prog_en   = shifting || (state_q == PROG_GO);
	assign prog_data = shifting && sh_q[0];   // GO carries a zero

	// Enable never outside a busy window
	a_en_busy: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		prog_en |-> prog_busy);

endmodule

`default_nettype wire

// ==== source/timing_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module timing_gen (
	input  wire                    clk50m_bufg,
	input  wire                    RSTBTN,
	input  wire                    mode_load,    // Restart counters
	input  wire video_pkg::coord_t h_active_end,
	input  wire video_pkg::coord_t h_sync_start,
	input  wire video_pkg::coord_t h_sync_end,
	input  wire video_pkg::coord_t h_total,
	input  wire video_pkg::coord_t v_active_end,
	input  wire video_pkg::coord_t v_sync_start,
	input  wire video_pkg::coord_t v_sync_end,
	input  wire video_pkg::coord_t v_total,
	input  wire                    sync_neg,
	output video_pkg::coord_t      hcount,       // Counters, one cycle late
	output video_pkg::coord_t      vcount,
	output logic                   de_early,     // Aligned with hcount
	output logic                   hsync,        // Two cycles late
	output logic                   vsync,
	output logic                   de
);
	import video_pkg::*;

	coord_t h_q;
	coord_t v_q;
	logic   run_q;      // Set by the first mode_load
	logic   h_last;
	logic   v_last;
	logic   hs_act;     // Active-sense sync, stage 1
	logic   vs_act;
	logic   neg_q;

	assign h_last = (h_q == h_total - 11'd1);
	assign v_last = (v_q == v_total - 11'd1);

	////////////////////////////////////////////////////////////////////////////
	// Line and frame counters
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			h_q   <= '0;
			v_q   <= '0;
			run_q <= 1'b0;
		end else if (mode_load) begin
			h_q   <= '0;
			v_q   <= '0;
			run_q <= 1'b1;
		end else if (run_q) begin
			if (h_last) begin
				h_q <= '0;
				v_q <= v_last ? 11'd0 : v_q + 11'd1;   // Next line or frame wrap
			end else begin
				h_q <= h_q + 11'd1;
			end
		end
	end

	// Stage 1 decode
	always_ff @(posedge clk50m_bufg) begin
		hcount <= h_q;
		vcount <= v_q;
	end

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			de_early <= 1'b0;
			hs_act   <= 1'b0;
			vs_act   <= 1'b0;
			neg_q    <= 1'b0;
		end else begin
			de_early <= run_q && (h_q < h_active_end) && (v_q < v_active_end);
			hs_act   <= run_q && (h_q >= h_sync_start) && (h_q < h_sync_end);
			vs_act   <= run_q && (v_q >= v_sync_start) && (v_q < v_sync_end);
			neg_q    <= run_q && sync_neg;   // Held inactive-low until first load
		end
	end

	// Stage 2, lines up with the registered colour bars
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			de    <= 1'b0;
		end else begin
			hsync <= hs_act ^ neg_q;
			vsync <= vs_act ^ neg_q;
			de    <= de_early;
		end
	end

	// Thresholds from mode_select must put sync inside blanking
	a_sync_blank: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!(de_early && hs_act));

endmodule

`default_nettype wire

// ==== source/color_bar.sv ====
`timescale 1ns/10ps
`default_nettype none

module color_bar (
	input  wire                    clk50m_bufg,
	input  wire                    RSTBTN,
	input  wire video_pkg::coord_t hcount,
	input  wire                    de_early,
	input  wire video_pkg::coord_t h_active_end,  // Active width
	output video_pkg::pixel_t      red,
	output video_pkg::pixel_t      green,
	output video_pkg::pixel_t      blue
);
	import video_pkg::*;

	logic [13:0] h_x8;
	logic [2:0]  bar;      // 0 white ... 7 black

	assign h_x8 = {hcount, 3'b000};             // hcount * 8
	assign bar  = 3'(h_x8 / h_active_end);

	// White, yellow, cyan, green, magenta, red, blue, black
	// R off for bars 2,3,6,7; G off for 4..7; B off for odd bars
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || !de_early) begin
			red   <= '0;                          // Blank outside active area
			green <= '0;
			blue  <= '0;
		end else begin
			red   <= {8{~bar[1]}};
			green <= {8{~bar[2]}};
			blue  <= {8{~bar[0]}};
		end
	end

endmodule

`default_nettype wire

// ==== source/video_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module video_top (
	input  wire                      clk50m_bufg,
	input  wire                      RSTBTN,
	input  wire video_pkg::sw_code_t mode_sw,
	input  wire                      prog_done,   // From pixel clock synthesizer
	output wire                      prog_en,
	output wire                      prog_data,
	output wire                      prog_busy,
	output wire                      hsync,
	output wire                      vsync,
	output wire                      de,
	output wire video_pkg::pixel_t   red,
	output wire video_pkg::pixel_t   green,
	output wire video_pkg::pixel_t   blue
);
	import video_pkg::*;

	logic   mode_load;
	coord_t h_active_end, h_sync_start, h_sync_end, h_total;
	coord_t v_active_end, v_sync_start, v_sync_end, v_total;
	logic   sync_neg;
	div_t   pclk_m, pclk_d;
	coord_t hcount;
	logic   de_early;

	////////////////////////////////////////////////////////////////////////////
	// Mode select and synthesizer programming
	////////////////////////////////////////////////////////////////////////////
	mode_select i_mode_select (
		.clk50m_bufg  (clk50m_bufg),
		.RSTBTN       (RSTBTN),
		.mode_sw      (mode_sw),
		.mode         (),              // Visible for debug only
		.mode_load    (mode_load),
		.h_active_end (h_active_end),
		.h_sync_start (h_sync_start),
		.h_sync_end   (h_sync_end),
		.h_total      (h_total),
		.v_active_end (v_active_end),
		.v_sync_start (v_sync_start),
		.v_sync_end   (v_sync_end),
		.v_total      (v_total),
		.sync_neg     (sync_neg),
		.pclk_m       (pclk_m),
		.pclk_d       (pclk_d)
	);

	dcm_prog i_dcm_prog (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.mode_load   (mode_load),
		.pclk_m      (pclk_m),
		.pclk_d      (pclk_d),
		.prog_done   (prog_done),
		.prog_en     (prog_en),
		.prog_data   (prog_data),
		.prog_busy   (prog_busy)
	);

	////////////////////////////////////////////////////////////////////////////
	// Video path
	////////////////////////////////////////////////////////////////////////////
	timing_gen i_timing_gen (
		.clk50m_bufg  (clk50m_bufg),
		.RSTBTN       (RSTBTN),
		.mode_load    (mode_load),
		.h_active_end (h_active_end),
		.h_sync_start (h_sync_start),
		.h_sync_end   (h_sync_end),
		.h_total      (h_total),
		.v_active_end (v_active_end),
		.v_sync_start (v_sync_start),
		.v_sync_end   (v_sync_end),
		.v_total      (v_total),
		.sync_neg     (sync_neg),
		.hcount       (hcount),
		.vcount       (),              // Bars only need the column
		.de_early     (de_early),
		.hsync        (hsync),
		.vsync        (vsync),
		.de           (de)
	);

	color_bar i_color_bar (
		.clk50m_bufg  (clk50m_bufg),
		.RSTBTN       (RSTBTN),
		.hcount       (hcount),
		.de_early     (de_early),
		.h_active_end (h_active_end),
		.red          (red),
		.green        (green),
		.blue         (blue)
	);

endmodule

`default_nettype wire

// ==== dv/tb_video_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "video_macros.svh"

module tb_video_top;

	logic        clk50m_bufg;
	logic        RSTBTN;
	logic [3:0]  mode_sw;
	logic        prog_done;
	wire         prog_en;
	wire         prog_data;
	wire         prog_busy;
	wire         hsync;
	wire         vsync;
	wire         de;
	wire [7:0]   red;
	wire [7:0]   green;
	wire [7:0]   blue;

	int          mismatch_cnt;
	int          other_errs;
	int unsigned seed;

	// Reference table, one row per mode: 0 VGA, 1 SVGA, 2 XGA, 3 720p, 4 SXGA
	string       name [5];
	logic [3:0]  code [5];
	int          hpx [5];
	int          htot [5];
	int          hsw [5];
	int          vln [5];
	int          vtot [5];
	bit          neg_m [5];   // 1 = negative sync
	int          mval [5];
	int          dval [5];

	video_top i_dut (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.mode_sw     (mode_sw),
		.prog_done   (prog_done),
		.prog_en     (prog_en),
		.prog_data   (prog_data),
		.prog_busy   (prog_busy),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.red         (red),
		.green       (green),
		.blue        (blue)
	);

	always #10 clk50m_bufg = ~clk50m_bufg;    // 50 MHz

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////
	task automatic set_mode(input int idx, input string nm, input logic [3:0] c,
		input int hp, input int hf, input int hs, input int hb,
		input int vl, input int vf, input int vs, input int vb,
		input bit ng, input int m, input int d);
		name[idx]  = nm;
		code[idx]  = c;
		hpx[idx]   = hp;
		htot[idx]  = hp + hf + hs + hb;   // Full line in cycles
		hsw[idx]   = hs;
		vln[idx]   = vl;
		vtot[idx]  = vl + vf + vs + vb;
		neg_m[idx] = ng;
		mval[idx]  = m;
		dval[idx]  = d;
	endtask

	// Expected {prog_en, prog_data} for sample i of a programming sequence
	function automatic logic [1:0] prog_bit(input int idx, input int i);
		logic [9:0] frame_d;
		logic [9:0] frame_m;
		frame_d = {8'(dval[idx] - 1), `OP_LOAD_D};   // Opcode goes out first
		frame_m = {8'(mval[idx] - 1), `OP_LOAD_M};
		if (i < 10) begin
			return {1'b1, frame_d[i]};
		end else if (i < 11) begin
			return 2'b00;                          // Gap after D
		end else if (i < 21) begin
			return {1'b1, frame_m[i - 11]};
		end else if (i < 22) begin
			return 2'b00;
		end
		return 2'b10;                              // GO
	endfunction

	// Bar colours as {red, green, blue}
	function automatic logic [23:0] bar_color(input int bar);
		case (bar)
			0:       return 24'hffffff;   // White
			1:       return 24'hffff00;   // Yellow
			2:       return 24'h00ffff;   // Cyan
			3:       return 24'h00ff00;
			4:       return 24'hff00ff;   // Magenta
			5:       return 24'hff0000;
			6:       return 24'h0000ff;
			default: return 24'h000000;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks and run control
	////////////////////////////////////////////////////////////////////////////
	task automatic check_value(input string test, input int exp, input int act);
		assert (exp == act) else begin
			$display("mismatch %s: expected %0d, actual %0d", test, exp, act);
			mismatch_cnt++;
		end
	endtask

	task automatic end_run();
		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_errs);
		if (mismatch_cnt == 0 && other_errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	task automatic timeout_fail(input string what);
		other_errs++;
		$display("error: timed out %s", what);
		end_run();
	endtask

	task automatic drive_switch(input logic [3:0] c);
		@(posedge clk50m_bufg);
		#1 mode_sw = c;
	endtask

	task automatic drive_done(input logic v);
		@(posedge clk50m_bufg);
		#1 prog_done = v;
	endtask

	task automatic check_reset_state(input string when);
		check_value({"reset de ", when}, 0, de);
		check_value({"reset prog_en ", when}, 0, prog_en);
		check_value({"reset prog_busy ", when}, 0, prog_busy);
		check_value({"reset hsync ", when}, 0, hsync);    // 720p default is positive
		check_value({"reset vsync ", when}, 0, vsync);
	endtask

	// Serial stream, busy window and done handshake for one mode change
	task automatic check_program(input int idx);
		int          n;
		int          i;
		int unsigned delay;
		logic [1:0]  exp;
		for (n = 0; n < 100 && !prog_en; n++) begin
			@(negedge clk50m_bufg);
		end
		if (!prog_en) begin
			timeout_fail($sformatf("waiting for prog_en, mode %s", name[idx]));
		end
		for (i = 0; i < 23; i++) begin
			exp = prog_bit(idx, i);
			check_value($sformatf("prog_en %s bit %0d", name[idx], i), exp[1], prog_en);
			check_value($sformatf("prog_data %s bit %0d", name[idx], i), exp[0], prog_data);
			check_value($sformatf("prog_busy %s bit %0d", name[idx], i), 1, prog_busy);
			@(negedge clk50m_bufg);
		end
		delay = $urandom % 30;   // Synthesizer lock time
		repeat (delay) begin
			check_value($sformatf("busy in wait %s", name[idx]), 1, prog_busy);
			check_value($sformatf("prog_en in wait %s", name[idx]), 0, prog_en);
			@(negedge clk50m_bufg);
		end
		drive_done(1'b1);
		for (n = 0; n < 10 && prog_busy; n++) begin
			@(negedge clk50m_bufg);
		end
		if (prog_busy) begin
			timeout_fail($sformatf("waiting for prog_busy to fall, mode %s", name[idx]));
		end
		check_value($sformatf("busy fall delay %s", name[idx]), 2, n);
		drive_done(1'b0);
	endtask

	// Waits on falling clock edges for the active-going edge of a sync
	task automatic wait_sync_rise(input bit use_v, input bit neg, input int limit,
		input string what);
		bit prev;
		bit cur;
		int n;
		prev = 1'b1;
		cur  = 1'b1;
		for (n = 0; n < limit && !(cur && !prev); n++) begin
			@(negedge clk50m_bufg);
			prev = cur;
			cur  = (use_v ? vsync : hsync) ^ neg;
		end
		if (!(cur && !prev)) begin
			timeout_fail(what);
		end
	endtask

	// Period, sync width, de count and bar colours, sync start to sync start
	task automatic measure_lines(input int idx, input int nlines);
		int ln;
		int n;
		int period;
		int width;
		int de_cnt;
		bit prev;
		bit cur;
		bit done;
		wait_sync_rise(1'b0, neg_m[idx], 4 * htot[idx],
			$sformatf("waiting for hsync, mode %s", name[idx]));
		for (ln = 0; ln < nlines; ln++) begin
			period = 0;
			width  = 0;
			de_cnt = 0;
			prev   = 1'b0;
			done   = 1'b0;
			for (n = 0; n < 2 * htot[idx] && !done; n++) begin
				cur = hsync ^ neg_m[idx];
				if (cur && !prev && n > 0) begin
					done = 1'b1;                   // Next line starts here
				end else begin
					period++;
					if (cur) begin
						width++;
					end
					if (de) begin
						check_value($sformatf("bar colour %s px %0d", name[idx], de_cnt),
							bar_color(de_cnt * 8 / hpx[idx]), {red, green, blue});
						de_cnt++;
					end
					prev = cur;
					@(negedge clk50m_bufg);
				end
			end
			if (!done) begin
				timeout_fail($sformatf("waiting for next hsync, mode %s", name[idx]));
			end
			check_value($sformatf("hsync period %s", name[idx]), htot[idx], period);
			check_value($sformatf("hsync width %s", name[idx]), hsw[idx], width);
			check_value($sformatf("de per line %s", name[idx]), hpx[idx], de_cnt);
		end
	endtask

	task automatic check_frame(input int idx);
		int n;
		int lines;
		bit prev_v;
		bit cur_v;
		bit prev_de;
		bit done;
		wait_sync_rise(1'b1, neg_m[idx], 2 * vtot[idx] * htot[idx],
			$sformatf("waiting for vsync, mode %s", name[idx]));
		lines   = 0;
		prev_v  = 1'b1;                            // Already inside the sync pulse
		prev_de = de;
		done    = 1'b0;
		for (n = 0; n < 2 * vtot[idx] * htot[idx] && !done; n++) begin
			@(negedge clk50m_bufg);
			cur_v = vsync ^ neg_m[idx];
			if (de && !prev_de) begin
				lines++;                           // One de burst per active line
			end
			if (cur_v && !prev_v) begin
				done = 1'b1;
			end
			prev_v  = cur_v;
			prev_de = de;
		end
		if (!done) begin
			timeout_fail($sformatf("waiting for next vsync, mode %s", name[idx]));
		end
		check_value($sformatf("vsync period %s", name[idx]), vtot[idx] * htot[idx], n);
		check_value($sformatf("de lines %s", name[idx]), vln[idx], lines);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////
	initial begin
		int order [5];
		int k;
		int j;
		int t;
		int last;
		int g;
		int glen;
		clk50m_bufg  = 1'b0;
		RSTBTN       = 1'b1;
		mode_sw      = 4'b0111;   // Unlisted code, falls back to 720p
		prog_done    = 1'b0;
		mismatch_cnt = 0;
		other_errs   = 0;
		seed         = 91;
		void'($urandom(seed));

		set_mode(0, "VGA", `SW_VGA, `VGA_HPX, `VGA_HFP, `VGA_HSW, `VGA_HBP,
			`VGA_VLN, `VGA_VFP, `VGA_VSW, `VGA_VBP, `VGA_NEG, `VGA_M, `VGA_D);
		set_mode(1, "SVGA", `SW_SVGA, `SVGA_HPX, `SVGA_HFP, `SVGA_HSW, `SVGA_HBP,
			`SVGA_VLN, `SVGA_VFP, `SVGA_VSW, `SVGA_VBP, `SVGA_NEG, `SVGA_M, `SVGA_D);
		set_mode(2, "XGA", `SW_XGA, `XGA_HPX, `XGA_HFP, `XGA_HSW, `XGA_HBP,
			`XGA_VLN, `XGA_VFP, `XGA_VSW, `XGA_VBP, `XGA_NEG, `XGA_M, `XGA_D);
		set_mode(3, "HD720P", `SW_HD720P, `HD720P_HPX, `HD720P_HFP, `HD720P_HSW,
			`HD720P_HBP, `HD720P_VLN, `HD720P_VFP, `HD720P_VSW, `HD720P_VBP,
			`HD720P_NEG, `HD720P_M, `HD720P_D);
		set_mode(4, "SXGA", `SW_SXGA, `SXGA_HPX, `SXGA_HFP, `SXGA_HSW, `SXGA_HBP,
			`SXGA_VLN, `SXGA_VFP, `SXGA_VSW, `SXGA_VBP, `SXGA_NEG, `SXGA_M, `SXGA_D);

		// Reset for 4 rising edges
		repeat (3) begin
			@(negedge clk50m_bufg);
			check_reset_state("during reset");
		end
		@(posedge clk50m_bufg);
		#1 RSTBTN = 1'b0;
		@(negedge clk50m_bufg);
		check_reset_state("after reset");
		check_program(3);                        // Reset-time load, 720p

		// Shuffled visit of all five modes
		for (k = 0; k < 5; k++) begin
			order[k] = k;
		end
		for (k = 4; k > 0; k--) begin
			j        = $urandom % (k + 1);
			t        = order[k];
			order[k] = order[j];
			order[j] = t;
		end
		for (k = 0; k < 5; k++) begin
			drive_switch(code[order[k]]);
			check_program(order[k]);
			measure_lines(order[k], 2);
			if (order[k] == 0) begin
				check_frame(0);
			end
		end

		////////////////////////////////////////////////////////////////////////////
		// Switch glitch shorter than the debounce window
		////////////////////////////////////////////////////////////////////////////
		last = order[4];
		g    = (last + 1 + $urandom % 4) % 5;
		glen = 1 + $urandom % (`DEBOUNCE_CYCLES - 2);
		drive_switch(code[g]);
		repeat (glen - 1) @(posedge clk50m_bufg);
		drive_switch(code[last]);
		repeat (glen + `DEBOUNCE_CYCLES + 10) begin
			@(negedge clk50m_bufg);
			check_value("glitch prog_en", 0, prog_en);
		end
		measure_lines(last, 1);                  // Line length must be unchanged

		end_run();
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/video_pkg.sv
source/mode_select.sv
source/dcm_prog.sv
source/timing_gen.sv
source/color_bar.sv
source/video_top.sv
dv/tb_video_top.sv

// ==== Bender.yml ====
package:
  name: video_timing

sources:
  - include_dirs:
      - source
    files:
      - source/video_pkg.sv
      - source/mode_select.sv
      - source/dcm_prog.sv
      - source/timing_gen.sv
      - source/color_bar.sv
      - source/video_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/tb_video_top.sv
